//--- Makefile
# Verilator build and run for the meshed serial-link endpoint

VERILATOR ?= verilator
TOP       ?= tb_meshed_serial_link
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q -F "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- credit_link_port.sv
// credit-flow link port; the peer must start with NumCredits credits toward us
// and honour the same rules, the link itself carries no ready
`timescale 1ns/10ps

module credit_link_port import serial_link_pkg::*; (
  input  logic     clk_i,
  input  logic     reset_i,
  flit_if.consumer tx,
  flit_if.producer rx,
  output logic     link_out_valid_o,
  output payload_t link_out_payload_o,
  input  logic     link_in_valid_i,
  input  payload_t link_in_payload_i
);

  logic      tx_full_q;
  flit_t     tx_flit_q;
  logic      tx_fire;
  credit_t   credits_out_q;
  credit_t   credits_out_d;
  credit_t   credits_pend_q;
  credit_t   credits_pend_d;
  logic      force_send;
  logic      send;
  logic      in_credit_only;
  logic      push;
  logic      pop;
  flit_t     fifo_mem [NumCredits];
  flit_t     fifo_head;
  fifo_ptr_t wr_ptr_q;
  fifo_ptr_t rd_ptr_q;
  credit_t   fifo_cnt_q;

  ////////////////////////////////////////////////////////////
  // transmit side
  ////////////////////////////////////////////////////////////

  assign tx.ready = ~tx_full_q;
  assign tx_fire  = tx.valid & tx.ready;

  always_comb begin
    force_send = credits_pend_q >= credit_t'(ForceSendThresh);
    send       = tx_full_q | force_send;
    if (credits_out_q == '0) begin
      send = 1'b0;
    end else if (credits_out_q == credit_t'(1) && credits_pend_q == '0) begin
      // keep the last credit so the peer can still hear our returns
      send = 1'b0;
    end
  end

  assign link_out_valid_o            = send;
  assign link_out_payload_o.has_flit = tx_full_q;
  assign link_out_payload_o.flit     = tx_flit_q;
  assign link_out_payload_o.credit   = credits_pend_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tx_full_q <= 1'b0;
    end else if (tx_fire) begin
      tx_full_q <= 1'b1;
    end else if (send) begin
      tx_full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (tx_fire) tx_flit_q <= '{data: tx.data, last: tx.last, src_id: tx.src_id};
  end

  ////////////////////////////////////////////////////////////
  // credit counters
  ////////////////////////////////////////////////////////////

  assign in_credit_only = link_in_valid_i & ~link_in_payload_i.has_flit;
  assign push           = link_in_valid_i & link_in_payload_i.has_flit;

  always_comb begin
    credits_out_d  = credits_out_q;
    credits_pend_d = credits_pend_q;
    // a sent packet uses one credit and carries every pending return
    if (send) begin
      credits_out_d  = credits_out_d - credit_t'(1);
      credits_pend_d = '0;
    end
    if (link_in_valid_i) credits_out_d = credits_out_d + link_in_payload_i.credit;
    // credit-only packets free their slot at once, data waits for the pop
    if (in_credit_only) credits_pend_d = credits_pend_d + credit_t'(1);
    if (pop) credits_pend_d = credits_pend_d + credit_t'(1);
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      credits_out_q  <= credit_t'(NumCredits);
      credits_pend_q <= '0;
    end else begin
      credits_out_q  <= credits_out_d;
      credits_pend_q <= credits_pend_d;
    end
  end

  ////////////////////////////////////////////////////////////
  // receive FIFO
  ////////////////////////////////////////////////////////////

  assign fifo_head = fifo_mem[rd_ptr_q];
  assign rx.valid  = fifo_cnt_q != '0;
  assign rx.data   = fifo_head.data;
  assign rx.last   = fifo_head.last;
  assign rx.src_id = fifo_head.src_id;
  assign pop       = rx.valid & rx.ready;

  always_ff @(posedge clk_i) begin
    if (push) fifo_mem[wr_ptr_q] <= link_in_payload_i.flit;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      fifo_cnt_q <= '0;
    end else begin
      if (push) wr_ptr_q <= wr_ptr_q + fifo_ptr_t'(1);
      if (pop) rd_ptr_q <= rd_ptr_q + fifo_ptr_t'(1);
      if (push && !pop) begin
        fifo_cnt_q <= fifo_cnt_q + credit_t'(1);
      end else if (pop && !push) begin
        fifo_cnt_q <= fifo_cnt_q - credit_t'(1);
      end
    end
  end

  // the peer only sends against credits we handed out
  a_no_push_full: assert property (@(posedge clk_i) disable iff (reset_i)
    push |-> fifo_cnt_q != credit_t'(NumCredits));

  // credits toward the peer never exceed its FIFO depth
  a_credit_max: assert property (@(posedge clk_i) disable iff (reset_i)
    credits_out_q <= credit_t'(NumCredits));

endmodule

//--- data_fetcher.sv
// reads fetch_len_i words and turns them into flits; responses must come back in order
// a start with a zero length is ignored and gives no send_done_o
`timescale 1ns/10ps

module data_fetcher import serial_link_pkg::*; (
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     send_start_i,
  input  addr_t    fetch_addr_i,
  input  len_t     fetch_len_i,
  input  node_id_t src_id_i,
  output logic     send_done_o,
  output logic     rd_req_valid_o,
  input  logic     rd_req_ready_i,
  output addr_t    rd_req_addr_o,
  input  logic     rd_rsp_valid_i,
  output logic     rd_rsp_ready_o,
  input  word_t    rd_rsp_data_i,
  flit_if.producer tx
);

  fetch_state_e state_q;
  logic         start_q;
  logic         start_pulse;
  addr_t        req_addr_q;
  len_t         req_left_q;
  len_t         rsp_left_q;
  node_id_t     src_id_q;
  rd_credit_t   rd_credit_q;
  rd_credit_t   rd_credit_d;
  logic         req_fire;
  logic         rsp_fire;

  assign start_pulse = send_start_i & ~start_q;

  // requests go out while words remain and a read credit is free
  assign rd_req_valid_o = (state_q == FETCH_RUN) & (req_left_q != '0) & (rd_credit_q != '0);
  assign rd_req_addr_o  = req_addr_q;
  assign req_fire       = rd_req_valid_o & rd_req_ready_i;

  // a response is taken only when the link port can take the flit
  assign rd_rsp_ready_o = (state_q == FETCH_RUN) & tx.ready;
  assign rsp_fire       = rd_rsp_valid_i & rd_rsp_ready_o;

  assign tx.valid  = (state_q == FETCH_RUN) & rd_rsp_valid_i;
  assign tx.data   = rd_rsp_data_i;
  assign tx.last   = rsp_left_q == len_t'(1);
  assign tx.src_id = src_id_q;

  assign send_done_o = tx.valid & tx.ready & tx.last;

  always_comb begin
    rd_credit_d = rd_credit_q;
    if (req_fire && !rsp_fire) begin
      rd_credit_d = rd_credit_q - rd_credit_t'(1);
    end else if (rsp_fire && !req_fire) begin
      rd_credit_d = rd_credit_q + rd_credit_t'(1);
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q     <= FETCH_IDLE;
      start_q     <= 1'b0;
      req_left_q  <= '0;
      rsp_left_q  <= '0;
      rd_credit_q <= rd_credit_t'(MaxOutstandingReads);
    end else begin
      start_q     <= send_start_i;
      rd_credit_q <= rd_credit_d;
      if (state_q == FETCH_IDLE) begin
        if (start_pulse && fetch_len_i != '0) begin
          state_q    <= FETCH_RUN;
          req_left_q <= fetch_len_i;
          rsp_left_q <= fetch_len_i;
        end
      end else begin
        if (req_fire) req_left_q <= req_left_q - len_t'(1);
        if (rsp_fire) rsp_left_q <= rsp_left_q - len_t'(1);
        // done once the final word has left as a flit
        if (rsp_fire && tx.last) state_q <= FETCH_IDLE;
      end
    end
  end

  // sampled config and running address
  always_ff @(posedge clk_i) begin
    if (state_q == FETCH_IDLE && start_pulse) begin
      req_addr_q <= fetch_addr_i;
      src_id_q   <= src_id_i;
    end else if (req_fire) begin
      req_addr_q <= req_addr_q + addr_t'(WordBytes);
    end
  end

  // read responses never outnumber the requests issued
  a_rd_credit_max: assert property (@(posedge clk_i) disable iff (reset_i)
    rsp_fire && !req_fire |-> rd_credit_q != rd_credit_t'(MaxOutstandingReads));

endmodule

//--- data_writer.sv
// writes received flits to memory from the armed address, one word per write
// flits still queued after an overflow stay in the receive FIFO until the next arm
`timescale 1ns/10ps

module data_writer import serial_link_pkg::*; (
  input  logic     clk_i,
  input  logic     reset_i,
  flit_if.consumer rx,
  input  logic     recv_arm_i,
  input  logic     recv_clear_i,
  input  addr_t    recv_addr_i,
  input  len_t     recv_len_i,
  output logic     recv_done_o,
  output logic     recv_overflow_o,
  output node_id_t recv_src_id_o,
  output logic     wr_valid_o,
  input  logic     wr_ready_i,
  output addr_t    wr_addr_o,
  output word_t    wr_data_o
);

  recv_state_e state_q;
  recv_state_e state_d;
  addr_t       next_addr_q;
  len_t        len_q;
  len_t        cnt_q;
  node_id_t    src_id_q;
  logic        wr_valid_q;
  addr_t       wr_addr_q;
  word_t       wr_data_q;
  logic        arm;
  logic        pop;
  logic        len_full;
  logic        do_write;

  assign arm      = (state_q == RECV_IDLE) & recv_arm_i;
  // pop only when the write register is free or draining this cycle
  assign rx.ready = (state_q == RECV_ACTIVE) & (~wr_valid_q | wr_ready_i);
  assign pop      = rx.valid & rx.ready;
  assign len_full = cnt_q == len_q;
  assign do_write = pop & ~len_full;

  always_comb begin
    state_d = state_q;
    case (state_q)
      RECV_IDLE: begin
        if (recv_arm_i) state_d = RECV_ACTIVE;
      end
      RECV_ACTIVE: begin
        if (pop && len_full) begin
          state_d = RECV_OVERFLOW;
        end else if (pop && rx.last) begin
          state_d = RECV_DONE;
        end
      end
      default: state_d = state_q;
    endcase
    if (recv_clear_i) state_d = RECV_IDLE;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q    <= RECV_IDLE;
      wr_valid_q <= 1'b0;
      cnt_q      <= '0;
    end else begin
      state_q <= state_d;
      if (do_write) begin
        wr_valid_q <= 1'b1;
      end else if (wr_ready_i) begin
        wr_valid_q <= 1'b0;
      end
      if (arm) begin
        cnt_q <= '0;
      end else if (do_write) begin
        cnt_q <= cnt_q + len_t'(1);
      end
    end
  end

  // address, length and write payload
  always_ff @(posedge clk_i) begin
    if (arm) begin
      next_addr_q <= recv_addr_i;
      len_q       <= recv_len_i;
    end else if (do_write) begin
      next_addr_q <= next_addr_q + addr_t'(WordBytes);
    end
    if (do_write) begin
      wr_addr_q <= next_addr_q;
      wr_data_q <= rx.data;
      src_id_q  <= rx.src_id;
    end
  end

  assign wr_valid_o      = wr_valid_q;
  assign wr_addr_o       = wr_addr_q;
  assign wr_data_o       = wr_data_q;
  assign recv_done_o     = state_q == RECV_DONE;
  assign recv_overflow_o = state_q == RECV_OVERFLOW;
  assign recv_src_id_o   = src_id_q;

  a_wr_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    wr_valid_o && !wr_ready_i |=> wr_valid_o && $stable(wr_data_o) && $stable(wr_addr_o));

endmodule

//--- flit_if.sv
// valid/ready flit channel; valid and fields hold steady until ready is seen
`timescale 1ns/10ps

interface flit_if import serial_link_pkg::*; ();

  logic     valid;
  logic     ready;
  word_t    data;
  logic     last;
  node_id_t src_id;

  modport producer (
    output valid,
    output data,
    output last,
    output src_id,
    input  ready
  );

  modport consumer (
    input  valid,
    input  data,
    input  last,
    input  src_id,
    output ready
  );

endinterface

//--- meshed_serial_link.sv
// serial-link endpoint: fetcher -> credit link port -> writer, one link, one peer
`timescale 1ns/10ps

module meshed_serial_link import serial_link_pkg::*; (
  input  logic     clk_i,
  input  logic     reset_i,
  // fetch side
  input  logic     send_start_i,
  input  addr_t    fetch_addr_i,
  input  len_t     fetch_len_i,
  input  node_id_t src_id_i,
  output logic     send_done_o,
  output logic     rd_req_valid_o,
  input  logic     rd_req_ready_i,
  output addr_t    rd_req_addr_o,
  input  logic     rd_rsp_valid_i,
  output logic     rd_rsp_ready_o,
  input  word_t    rd_rsp_data_i,
  // serial link
  output logic     link_out_valid_o,
  output payload_t link_out_payload_o,
  input  logic     link_in_valid_i,
  input  payload_t link_in_payload_i,
  // receive side
  input  logic     recv_arm_i,
  input  logic     recv_clear_i,
  input  addr_t    recv_addr_i,
  input  len_t     recv_len_i,
  output logic     recv_done_o,
  output logic     recv_overflow_o,
  output node_id_t recv_src_id_o,
  output logic     wr_valid_o,
  input  logic     wr_ready_i,
  output addr_t    wr_addr_o,
  output word_t    wr_data_o
);

  flit_if tx_flit ();
  flit_if rx_flit ();

  data_fetcher data_fetcher_i (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .send_start_i   (send_start_i),
    .fetch_addr_i   (fetch_addr_i),
    .fetch_len_i    (fetch_len_i),
    .src_id_i       (src_id_i),
    .send_done_o    (send_done_o),
    .rd_req_valid_o (rd_req_valid_o),
    .rd_req_ready_i (rd_req_ready_i),
    .rd_req_addr_o  (rd_req_addr_o),
    .rd_rsp_valid_i (rd_rsp_valid_i),
    .rd_rsp_ready_o (rd_rsp_ready_o),
    .rd_rsp_data_i  (rd_rsp_data_i),
    .tx             (tx_flit.producer)
  );

  credit_link_port credit_link_port_i (
    .clk_i              (clk_i),
    .reset_i            (reset_i),
    .tx                 (tx_flit.consumer),
    .rx                 (rx_flit.producer),
    .link_out_valid_o   (link_out_valid_o),
    .link_out_payload_o (link_out_payload_o),
    .link_in_valid_i    (link_in_valid_i),
    .link_in_payload_i  (link_in_payload_i)
  );

  data_writer data_writer_i (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .rx              (rx_flit.consumer),
    .recv_arm_i      (recv_arm_i),
    .recv_clear_i    (recv_clear_i),
    .recv_addr_i     (recv_addr_i),
    .recv_len_i      (recv_len_i),
    .recv_done_o     (recv_done_o),
    .recv_overflow_o (recv_overflow_o),
    .recv_src_id_o   (recv_src_id_o),
    .wr_valid_o      (wr_valid_o),
    .wr_ready_i      (wr_ready_i),
    .wr_addr_o       (wr_addr_o),
    .wr_data_o       (wr_data_o)
  );

endmodule

//--- serial_link_pkg.sv
// shared widths, credit constants and link types for the serial-link endpoint
// NumCredits must be a power of two, since the receive FIFO pointers wrap freely
package serial_link_pkg;

  ////////////////////////////////////////////////////////////
  // widths and limits
  ////////////////////////////////////////////////////////////

  localparam int DataWidth   = 32;
  localparam int WordBytes   = DataWidth / 8;
  localparam int AddrWidth   = 16;
  localparam int LenWidth    = 8;
  localparam int NodeIdWidth = 4;

  // receive FIFO depth, also the initial credit count toward the peer
  localparam int NumCredits          = 8;
  localparam int ForceSendThresh     = NumCredits - 4;
  localparam int MaxOutstandingReads = 3;

  typedef logic [DataWidth-1:0]   word_t;
  typedef logic [AddrWidth-1:0]   addr_t;
  typedef logic [LenWidth-1:0]    len_t;
  typedef logic [NodeIdWidth-1:0] node_id_t;

  // wide enough for 0 .. NumCredits
  typedef logic [3:0] credit_t;
  typedef logic [$clog2(NumCredits)-1:0] fifo_ptr_t;
  typedef logic [$clog2(MaxOutstandingReads+1)-1:0] rd_credit_t;

  ////////////////////////////////////////////////////////////
  // flit and link packet
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    word_t    data;
    logic     last;
    node_id_t src_id;
  } flit_t;

  // has_flit low means a credit-only packet
  typedef struct packed {
    logic    has_flit;
    flit_t   flit;
    credit_t credit;
  } payload_t;

  typedef enum logic {
    FETCH_IDLE,
    FETCH_RUN
  } fetch_state_e;

  typedef enum logic [1:0] {
    RECV_IDLE,
    RECV_ACTIVE,
    RECV_DONE,
    RECV_OVERFLOW
  } recv_state_e;

endpackage

//--- tb_meshed_serial_link.sv
// directed testbench; read memory is random with random latency, the peer loops back or is silent
// every test starts from a fresh reset, addresses stay below 4 KiB
`timescale 1ns/10ps

module tb_meshed_serial_link import serial_link_pkg::*; ();

  // reset 6x16, loopback 600, exhaustion 700, credit return 400, overflow 600, back-pressure 1500
  localparam int CycleLimit = 4000;

  logic     clk;
  logic     reset_i;
  logic     send_start_i;
  addr_t    fetch_addr_i;
  len_t     fetch_len_i;
  node_id_t src_id_i;
  logic     send_done_o;
  logic     rd_req_valid_o;
  logic     rd_req_ready_i;
  addr_t    rd_req_addr_o;
  logic     rd_rsp_valid_i;
  logic     rd_rsp_ready_o;
  word_t    rd_rsp_data_i;
  logic     link_out_valid_o;
  payload_t link_out_payload_o;
  logic     link_in_valid_i;
  payload_t link_in_payload_i;
  logic     recv_arm_i;
  logic     recv_clear_i;
  addr_t    recv_addr_i;
  len_t     recv_len_i;
  logic     recv_done_o;
  logic     recv_overflow_o;
  node_id_t recv_src_id_o;
  logic     wr_valid_o;
  logic     wr_ready_i;
  addr_t    wr_addr_o;
  word_t    wr_data_o;

  integer   seed = 32'h035e5d07;
  word_t    rd_mem [1024];
  addr_t    rsp_pending [$];
  addr_t    wr_addr_log [$];
  word_t    wr_data_log [$];
  logic     rsp_taken;
  logic     peer_loop;
  logic     wr_rand;
  logic     lb_valid;
  payload_t lb_payload;
  payload_t first_pkt;
  int       outstanding;
  int       pkt_cnt;
  int       credit_sum;
  int       done_cnt;
  int       cycle_cnt;
  int       errors;
  int       checks;
  int       tests;

  meshed_serial_link meshed_serial_link_i (.*, .clk_i(clk));

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= CycleLimit) begin
      $display("error: run exceeded the limit of %0d cycles", CycleLimit);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // monitors, sampled on the rising edge
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (reset_i) begin
      rsp_pending.delete();
      wr_addr_log.delete();
      wr_data_log.delete();
      rsp_taken   = 1'b0;
      lb_valid    = 1'b0;
      outstanding = 0;
      pkt_cnt     = 0;
      credit_sum  = 0;
      done_cnt    = 0;
    end else begin
      if (rd_req_valid_o && rd_req_ready_i) begin
        rsp_pending.push_back(rd_req_addr_o);
        outstanding++;
      end
      if (rd_rsp_valid_i && rd_rsp_ready_o) begin
        rsp_taken = 1'b1;
        outstanding--;
      end
      if (outstanding > MaxOutstandingReads) begin
        $display("error at %0t: %0d reads outstanding", $time, outstanding);
        errors++;
      end
      if (wr_valid_o && wr_ready_i) begin
        wr_addr_log.push_back(wr_addr_o);
        wr_data_log.push_back(wr_data_o);
      end
      if (link_out_valid_o) begin
        if (pkt_cnt == 0) first_pkt = link_out_payload_o;
        pkt_cnt++;
        credit_sum += int'(link_out_payload_o.credit);
      end
      if (send_done_o) done_cnt++;
      lb_valid   = link_out_valid_o;
      lb_payload = link_out_payload_o;
    end
  end

  ////////////////////////////////////////////////////////////
  // memory and peer models, driven on the falling edge
  ////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    word_t rnd;
    rnd = $random(seed);
    wr_ready_i = wr_rand ? rnd[0] : 1'b1;
    if (reset_i) begin
      rd_rsp_valid_i = 1'b0;
    end else begin
      if (rsp_taken) begin
        rsp_taken      = 1'b0;
        rd_rsp_valid_i = 1'b0;
        void'(rsp_pending.pop_front());
      end
      // random latency, roughly one response in four cycles
      if (!rd_rsp_valid_i && rsp_pending.size() > 0 && rnd[5:4] == 2'b00) begin
        rd_rsp_valid_i = 1'b1;
        rd_rsp_data_i  = rd_mem[rsp_pending[0][11:2]];
      end
    end
    if (peer_loop) begin
      link_in_valid_i   = lb_valid;
      link_in_payload_i = lb_payload;
    end
  end

  ////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////

  task automatic compare_word(input word_t got, input word_t exp, input string what);
    checks++;
    if (got !== exp) begin
      $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic compare_addr(input addr_t got, input addr_t exp, input string what);
    checks++;
    if (got !== exp) begin
      $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic compare_id(input node_id_t got, input node_id_t exp, input string what);
    checks++;
    if (got !== exp) begin
      $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic compare_flag(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      $display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic compare_credit(input credit_t got, input credit_t exp, input string what);
    checks++;
    if (got !== exp) begin
      $display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic compare_count(input int got, input int exp, input string what);
    checks++;
    if (got != exp) begin
      $display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////

  task automatic apply_reset(input logic loop, input logic rand_wr);
    @(negedge clk);
    peer_loop       = loop;
    wr_rand         = rand_wr;
    reset_i         = 1'b1;
    link_in_valid_i = 1'b0;
    repeat (16) @(negedge clk);
    reset_i = 1'b0;
  endtask

  task automatic start_fetch(input addr_t addr, input len_t len, input node_id_t id);
    @(negedge clk);
    fetch_addr_i = addr;
    fetch_len_i  = len;
    src_id_i     = id;
    send_start_i = 1'b1;
    @(negedge clk);
    send_start_i = 1'b0;
  endtask

  task automatic arm_receiver(input addr_t addr, input len_t len);
    @(negedge clk);
    recv_addr_i = addr;
    recv_len_i  = len;
    recv_arm_i  = 1'b1;
    @(negedge clk);
    recv_arm_i = 1'b0;
  endtask

  task automatic inject_packet(input logic has_flit, input word_t data, input logic last,
                               input credit_t credit);
    payload_t p;
    p.has_flit       = has_flit;
    p.flit.data      = data;
    p.flit.last      = last;
    p.flit.src_id    = 4'h9;
    p.credit         = credit;
    @(negedge clk);
    link_in_valid_i   = 1'b1;
    link_in_payload_i = p;
    @(negedge clk);
    link_in_valid_i = 1'b0;
  endtask

  task automatic wait_writes(input int n, input int limit);
    int c;
    c = 0;
    while (wr_addr_log.size() < n && c < limit) begin
      @(negedge clk);
      c++;
    end
    if (wr_addr_log.size() < n) begin
      $display("error at %0t: only %0d of %0d writes seen", $time, wr_addr_log.size(), n);
      errors++;
    end
  endtask

  task automatic wait_packets(input int n, input int limit);
    int c;
    c = 0;
    while (pkt_cnt < n && c < limit) begin
      @(negedge clk);
      c++;
    end
  endtask

  // written words against the read memory, starting at word index base
  task automatic check_writes(input int n, input addr_t recv_addr, input int base);
    compare_count(wr_addr_log.size(), n, "write count");
    for (int i = 0; i < n && i < wr_addr_log.size(); i++) begin
      compare_addr(wr_addr_log[i], recv_addr + addr_t'(i * WordBytes), "wr_addr_o");
      compare_word(wr_data_log[i], rd_mem[base + i], "wr_data_o");
    end
  endtask

  task automatic report_test(input string name, input int err_start);
    tests++;
    $display("test %s: %s", name, (errors == err_start) ? "ok" : "failed");
  endtask

  ////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////

  task automatic test_reset();
    int e;
    e = errors;
    apply_reset(1'b1, 1'b0);
    compare_flag(rd_req_valid_o, 1'b0, "rd_req_valid_o");
    compare_flag(rd_rsp_ready_o, 1'b0, "rd_rsp_ready_o");
    compare_flag(link_out_valid_o, 1'b0, "link_out_valid_o");
    compare_flag(wr_valid_o, 1'b0, "wr_valid_o");
    compare_flag(send_done_o, 1'b0, "send_done_o");
    compare_flag(recv_done_o, 1'b0, "recv_done_o");
    compare_flag(recv_overflow_o, 1'b0, "recv_overflow_o");
    report_test("reset", e);
  endtask

  task automatic test_loopback();
    int e;
    e = errors;
    apply_reset(1'b1, 1'b0);
    arm_receiver(16'h0800, 8'd12);
    start_fetch(16'h0100, 8'd12, 4'h5);
    wait_writes(12, 600);
    @(negedge clk);
    check_writes(12, 16'h0800, 64);
    compare_flag(recv_done_o, 1'b1, "recv_done_o");
    compare_id(recv_src_id_o, 4'h5, "recv_src_id_o");
    compare_count(done_cnt, 1, "send_done_o pulses");
    report_test("loopback", e);
  endtask

  task automatic test_credit_exhaustion();
    int e;
    e = errors;
    apply_reset(1'b0, 1'b0);
    start_fetch(16'h0200, 8'd12, 4'h3);
    wait_packets(NumCredits - 1, 300);
    // sending must stay stopped
    repeat (40) @(negedge clk);
    compare_count(pkt_cnt, NumCredits - 1, "packets before credit return");
    inject_packet(1'b0, '0, 1'b0, credit_t'(4));
    wait_packets(NumCredits + 3, 300);
    repeat (40) @(negedge clk);
    compare_count(pkt_cnt, NumCredits + 3, "packets after credit return");
    report_test("credit_exhaustion", e);
  endtask

  task automatic test_credit_return();
    int e;
    int c;
    e = errors;
    apply_reset(1'b0, 1'b0);
    arm_receiver(16'h0a00, 8'd6);
    for (int i = 0; i < 6; i++) begin
      inject_packet(1'b1, rd_mem[64 + i], i == 5, '0);
    end
    wait_writes(6, 100);
    check_writes(6, 16'h0a00, 64);
    compare_flag(recv_done_o, 1'b1, "recv_done_o");
    compare_flag(first_pkt.has_flit, 1'b0, "first packet has_flit");
    compare_credit(first_pkt.credit, credit_t'(ForceSendThresh), "first packet credit");
    // a one-word fetch carries the remaining returns out
    start_fetch(16'h0300, 8'd1, 4'h1);
    c = 0;
    while (credit_sum < 6 && c < 200) begin
      @(negedge clk);
      c++;
    end
    repeat (4) @(negedge clk);
    compare_count(credit_sum, 6, "credits returned");
    report_test("credit_return", e);
  endtask

  task automatic test_overflow();
    int e;
    int c;
    e = errors;
    apply_reset(1'b1, 1'b0);
    arm_receiver(16'h0c00, 8'd5);
    start_fetch(16'h0400, 8'd9, 4'h7);
    c = 0;
    while (!recv_overflow_o && c < 600) begin
      @(negedge clk);
      c++;
    end
    repeat (4) @(negedge clk);
    check_writes(5, 16'h0c00, 256);
    compare_flag(recv_overflow_o, 1'b1, "recv_overflow_o");
    compare_flag(recv_done_o, 1'b0, "recv_done_o");
    @(negedge clk);
    recv_clear_i = 1'b1;
    @(negedge clk);
    recv_clear_i = 1'b0;
    compare_flag(recv_overflow_o, 1'b0, "recv_overflow_o after clear");
    compare_flag(recv_done_o, 1'b0, "recv_done_o after clear");
    report_test("overflow", e);
  endtask

  task automatic test_back_pressure();
    int e;
    e = errors;
    apply_reset(1'b1, 1'b1);
    arm_receiver(16'h0e00, 8'd16);
    start_fetch(16'h0500, 8'd16, 4'hb);
    wait_writes(16, 1500);
    check_writes(16, 16'h0e00, 320);
    compare_flag(recv_done_o, 1'b1, "recv_done_o");
    compare_id(recv_src_id_o, 4'hb, "recv_src_id_o");
    wr_rand = 1'b0;
    report_test("back_pressure", e);
  endtask

  initial begin
    reset_i           = 1'b1;
    send_start_i      = 1'b0;
    fetch_addr_i      = '0;
    fetch_len_i       = '0;
    src_id_i          = '0;
    rd_req_ready_i    = 1'b1;
    rd_rsp_valid_i    = 1'b0;
    rd_rsp_data_i     = '0;
    link_in_valid_i   = 1'b0;
    link_in_payload_i = '0;
    recv_arm_i        = 1'b0;
    recv_clear_i      = 1'b0;
    recv_addr_i       = '0;
    recv_len_i        = '0;
    wr_ready_i        = 1'b1;
    peer_loop         = 1'b1;
    wr_rand           = 1'b0;
    errors            = 0;
    checks            = 0;
    tests             = 0;
    cycle_cnt         = 0;
    for (int i = 0; i < 1024; i++) begin
      rd_mem[i] = $random(seed);
    end
    test_reset();
    test_loopback();
    test_credit_exhaustion();
    test_credit_return();
    test_overflow();
    test_back_pressure();
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- vlog.f
serial_link_pkg.sv
flit_if.sv
data_fetcher.sv
credit_link_port.sv
data_writer.sv
meshed_serial_link.sv
tb_meshed_serial_link.sv
